/* files.f */
+incdir+hw
hw/memcPkg.sv
hw/cacheBus.sv
hw/cacheBank.sv
hw/cacheInterface.sv
hw/memoryInterface.sv
hw/memoryController.sv
tb/memoryController_sva.sv
tb/memoryControllerTb.sv

/* Bender.yml */
package:
  name: memory_controller

sources:
  - include_dirs:
      - hw
    files:
      - hw/memcPkg.sv
      - hw/cacheBus.sv
      - hw/cacheBank.sv
      - hw/cacheInterface.sv
      - hw/memoryInterface.sv
      - hw/memoryController.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/memoryController_sva.sv
      - tb/memoryControllerTb.sv

/* tb/memoryControllerTb.sv */
`timescale 1ns/1ps

module memoryControllerTb import memcPkg::*; ();

    localparam int TOTAL_WORDS = 32 + 32 + 128 + 128 + 32 + 32;
    localparam int WATCHDOG_CYCLES = 4 * TOTAL_WORDS * 3 + 2000;
    localparam sramAddr_t BASE = 10'h040;  // Same slot in both banks

    logic      clk = 1'b0;
    logic      rst;
    memcCmd_t  cmd;
    logic      cacheId;
    sramAddr_t sramAddr;
    extAddr_t  extAddr;
    rqId_t     rqIdIn;
    logic      busy;
    logic      resultValid;
    rqId_t     rqIdOut;
    xferLen_t  progress;
    logic      extOen;
    logic      extEn;
    dataWord   extBusOut;
    logic      extStall = 1'b0;
    dataWord   extBusIn = '0;

    logic [31:0] lcgState = 32'h1e19_4c6a;
    int          errors = 0;
    int          checks = 0;
    int          testNum = 0;
    logic        stallOn = 1'b0;
    logic        hdrDone = 1'b0;
    logic        moved = 1'b1;        // Draws the first bus word
    int          oenLowCycles = 0;
    dataWord     hdrLog [$];
    dataWord     busLog [$];
    dataWord     expData [$];
    dataWord     bank0Data [$];

    always #20 clk = ~clk;

    memoryController u_memoryController (.*);

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int totalErrors();
        return errors + u_memoryController.u_sva.failCount;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int mark);
        testNum++;
        $display("test %0d %s: %s", testNum, name, (totalErrors() == mark) ? "ok" : "failed");
    endtask

    ////////////////////
    // External memory model

    always @(negedge clk) begin
        if (moved) extBusIn = nextRand();
        moved = 1'b0;
        extStall = (nextRand() < 32'h4000_0000) && stallOn;   // About one cycle in four
        if (!extEn) begin
            hdrDone = 1'b0;
        end
        else begin
            if (!extOen) oenLowCycles++;
            if (!extStall) begin
                if (!hdrDone) hdrLog.push_back(extBusOut);
                else busLog.push_back(extOen ? extBusOut : extBusIn);
                moved = hdrDone;
                hdrDone = 1'b1;
            end
        end
    end

    task automatic runTransfer(input memcCmd_t c, input logic bank, input extAddr_t ea,
                               input rqId_t tag, input logic stall, input logic stray);
        xferLen_t len;
        xferLen_t lenField;
        logic     toExt;
        int       hdrStart;
        int       wordStart;
        int       oenStart;
        len = bank ? 8'd128 : 8'd32;
        lenField = len - 1'b1;
        toExt = (c == MEMC_CP_CACHE_TO_EXT);
        hdrStart = hdrLog.size();
        wordStart = busLog.size();
        oenStart = oenLowCycles;
        stallOn = stall;
        cmd = c;
        cacheId = bank;
        sramAddr = BASE;
        extAddr = ea;
        rqIdIn = tag;
        @(negedge clk);
        cmd = MEMC_NONE;
        if (stray) begin
            repeat (4) @(negedge clk);
            checkValue("busy", busy, 1'b1);
            cmd = MEMC_CP_EXT_TO_CACHE;
            cacheId = 1'b1;
            rqIdIn = ~tag;
            @(negedge clk);
            cmd = MEMC_NONE;
        end
        while (!resultValid) @(negedge clk);
        checkValue("busy", busy, 1'b0);
        checkValue("rqIdOut", rqIdOut, tag);
        checkValue("progress", progress, len);
        @(negedge clk);
        checkValue("resultValid", resultValid, 1'b0);
        repeat (4) @(negedge clk);   // Room for a stray second header
        checkValue("header count", hdrLog.size() - hdrStart, 1);
        checkValue("extBusOut header", hdrLog[hdrStart], {toExt, lenField, ea[22:0]});
        checkValue("word count", busLog.size() - wordStart, len);
        checkValue("extOen steady", oenLowCycles == oenStart, toExt);
        if (!toExt) expData.delete();
        for (int i = 0; i < len; i++) begin
            if (toExt) checkValue("extBusOut", busLog[wordStart + i], expData[i]);
            else expData.push_back(busLog[wordStart + i]);
        end
    endtask

    initial begin
        int mark;
        rst = 1'b1;
        cmd = MEMC_NONE;
        cacheId = 1'b0;
        sramAddr = '0;
        extAddr = '0;
        rqIdIn = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        mark = totalErrors();
        repeat (5) @(negedge clk);
        reportTest("idle after reset", mark);

        mark = totalErrors();
        runTransfer(MEMC_CP_EXT_TO_CACHE, 1'b0, 30'h100, 4'h3, 1'b0, 1'b0);
        bank0Data = expData;
        reportTest("load bank 0", mark);

        mark = totalErrors();
        runTransfer(MEMC_CP_CACHE_TO_EXT, 1'b0, 30'h200, 4'h5, 1'b1, 1'b0);
        reportTest("store bank 0 under stall", mark);

        mark = totalErrors();
        runTransfer(MEMC_CP_EXT_TO_CACHE, 1'b1, 30'h300, 4'h9, 1'b1, 1'b0);
        runTransfer(MEMC_CP_CACHE_TO_EXT, 1'b1, 30'h400, 4'ha, 1'b1, 1'b0);
        reportTest("bank 1 round trip", mark);

        mark = totalErrors();
        expData = bank0Data;
        runTransfer(MEMC_CP_CACHE_TO_EXT, 1'b0, 30'h500, 4'h6, 1'b0, 1'b1);
        reportTest("command ignored while busy", mark);

        mark = totalErrors();
        expData = bank0Data;
        runTransfer(MEMC_CP_CACHE_TO_EXT, 1'b0, 30'h600, 4'hc, 1'b1, 1'b0);
        reportTest("bank 0 kept after bank 1 load", mark);

        $display("%0d tests, %0d checks, %0d errors", testNum, checks, totalErrors());
        if (totalErrors() == 0) begin
            $display("Result: PASSED");
        end
        else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all transfers completed");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* tb/memoryController_sva.sv */
`timescale 1ns/1ps

module memoryController_sva import memcPkg::*; (
    input logic     clk,
    input logic     rst,
    input memcCmd_t cmd,
    input logic     busy,
    input logic     resultValid,
    input rqId_t    rqIdOut,
    input xferLen_t progress,
    input logic     extEn,
    input logic     extOen
);

    int   failCount = 0;
    logic cmdSeen;

    always_ff @(posedge clk) begin
        if (rst) cmdSeen <= 1'b0;
        else if (cmd != MEMC_NONE) cmdSeen <= 1'b1;
    end

    // Everything quiet until the first request
    idleAfterReset: assert property (@(posedge clk) disable iff (rst)
        !cmdSeen |-> !busy && !resultValid && !extEn && !extOen)
        else begin
            $error("outputs active before the first command");
            failCount++;
        end

    donePulse: assert property (@(posedge clk) disable iff (rst)
        resultValid |=> !resultValid)
        else begin
            $error("resultValid held longer than one cycle");
            failCount++;
        end

    doneWithBusyFall: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) == resultValid)
        else begin
            $error("resultValid not aligned with busy falling");
            failCount++;
        end

    headerOen: assert property (@(posedge clk) disable iff (rst)
        $rose(extEn) |-> extOen)
        else begin
            $error("extOen low in the header cycle");
            failCount++;
        end

    tagAndProgress: assert property (@(posedge clk) disable iff (rst)
        busy ##1 busy |-> $stable(rqIdOut)
            && (progress == $past(progress) || progress == xferLen_t'($past(progress) + 1)))
        else begin
            $error("tag changed or progress jumped during a transfer");
            failCount++;
        end

endmodule

bind memoryController memoryController_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .busy        (busy),
    .resultValid (resultValid),
    .rqIdOut     (rqIdOut),
    .progress    (progress),
    .extEn       (extEn),
    .extOen      (extOen)
);

/* hw/memoryController.sv */
`timescale 1ns/1ps
`include "memc_params.svh"

module memoryController import memcPkg::*; #(
    parameter int NUM_BANKS = `MEMC_NUM_BANKS
) (
    input  logic     clk,
    input  logic     rst,
    input  memcCmd_t cmd,
    input  logic     cacheId,
    input  sramAddr_t sramAddr,
    input  extAddr_t extAddr,
    input  rqId_t    rqIdIn,
    output logic     busy,
    output logic     resultValid,
    output rqId_t    rqIdOut,
    output xferLen_t progress,
    output logic     extOen,
    output logic     extEn,
    output dataWord  extBusOut,
    input  logic     extStall,
    input  dataWord  extBusIn
);

    localparam xferLen_t BANK0_LEN = 8'd32;
    localparam xferLen_t BANK1_LEN = 8'd128;

    ctrlState_t state;
    logic       accept;
    logic       cacheWrite;
    xferLen_t   accessLen;
    logic       cacheBusy;
    logic       memBusy;
    logic       advance;
    dataWord    memToCache;
    dataWord    cacheToMem;
    logic       cacheValid;

    assign accept = (state == CTRL_IDLE) && (cmd != MEMC_NONE);
    assign cacheWrite = (cmd == MEMC_CP_EXT_TO_CACHE);
    assign accessLen = cacheId ? BANK1_LEN : BANK0_LEN;   // Fixed per bank
    assign busy = (state == CTRL_BUSY);

    ////////////////////
    // Sequencers and banks

    cacheBus #(.NUM_BANKS(NUM_BANKS)) cacheBusIf ();

    cacheInterface u_cacheInterface (
        .clk      (clk),
        .rst      (rst),
        .start    (accept),
        .write    (cacheWrite),
        .bank     (cacheId),
        .sramAddr (sramAddr),
        .len      (accessLen),
        .busy     (cacheBusy),
        .advance  (advance),
        .inData   (memToCache),
        .outData  (cacheToMem),
        .outValid (cacheValid),
        .cb       (cacheBusIf.seq)
    );

    memoryInterface u_memoryInterface (
        .clk       (clk),
        .rst       (rst),
        .start     (accept),
        .write     (cmd == MEMC_CP_CACHE_TO_EXT),
        .extAddr   (extAddr),
        .len       (accessLen),
        .busy      (memBusy),
        .advance   (advance),
        .inData    (cacheToMem),
        .inValid   (cacheValid),
        .outData   (memToCache),
        .extOen    (extOen),
        .extEn     (extEn),
        .extBusOut (extBusOut),
        .extStall  (extStall),
        .extBusIn  (extBusIn)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : gBank
        cacheBank #(.INDEX(i)) u_cacheBank (
            .clk (clk),
            .cb  (cacheBusIf.bank)
        );
    end

    ////////////////////
    // Request FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTRL_IDLE;
            resultValid <= 1'b0;
            progress <= '0;
        end
        else begin
            resultValid <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (accept) begin
                        state <= CTRL_BUSY;
                        rqIdOut <= rqIdIn;
                        progress <= '0;
                    end
                end
                CTRL_BUSY: begin
                    if (advance) progress <= progress + 1'b1;
                    if (!cacheBusy && !memBusy) begin
                        state <= CTRL_IDLE;
                        resultValid <= 1'b1;    // Single cycle done pulse
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

/* hw/memoryInterface.sv */
`timescale 1ns/1ps

module memoryInterface import memcPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  logic     write,
    input  extAddr_t extAddr,
    input  xferLen_t len,
    output logic     busy,
    output logic     advance,
    input  dataWord  inData,
    input  logic     inValid,
    output dataWord  outData,
    output logic     extOen,
    output logic     extEn,
    output dataWord  extBusOut,
    input  logic     extStall,
    input  dataWord  extBusIn
);

    extState_t state;
    logic      writeQ;
    extAddr_t  addrQ;
    xferLen_t  lenQ;
    xferLen_t  remaining;
    xferLen_t  lenField;
    dataWord   header;

    ////////////////////
    // Header and bus drive

    assign lenField = lenQ - 1'b1;
    assign header = {writeQ, lenField, addrQ[22:0]};    // Flag, len-1, low address

    assign busy = (state != EXT_IDLE);
    assign extEn = busy;
    assign outData = extBusIn;

    // A word moves only when the far side is not stalling
    assign advance = (state == EXT_DATA) && !extStall && (!writeQ || inValid);

    always_comb begin
        extOen = 1'b0;
        extBusOut = '0;
        case (state)
            EXT_HEADER: begin
                extOen = 1'b1;
                extBusOut = header;
            end
            EXT_DATA: begin
                extOen = writeQ;
                extBusOut = writeQ ? inData : '0;
            end
            default: begin
                extOen = 1'b0;
            end
        endcase
    end

    ////////////////////
    // Sequencer

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EXT_IDLE;
            writeQ <= 1'b0;
            remaining <= '0;
        end
        else begin
            case (state)
                EXT_IDLE: begin
                    if (start) begin
                        state <= EXT_HEADER;
                        writeQ <= write;
                        remaining <= len;
                    end
                end
                EXT_HEADER: begin
                    if (!extStall) state <= EXT_DATA;
                end
                EXT_DATA: begin
                    if (advance) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == xferLen_t'(1)) state <= EXT_IDLE;   // Last word
                    end
                end
                default: state <= EXT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXT_IDLE && start) begin
            addrQ <= extAddr;
            lenQ <= len;
        end
    end

endmodule

/* hw/cacheInterface.sv */
`timescale 1ns/1ps

module cacheInterface import memcPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      write,
    input  logic      bank,
    input  sramAddr_t sramAddr,
    input  xferLen_t  len,
    output logic      busy,
    input  logic      advance,
    input  dataWord   inData,
    output dataWord   outData,
    output logic      outValid,
    cacheBus.seq      cb
);

    logic      writeQ;
    logic      bankQ;
    sramAddr_t addrQ;
    xferLen_t  remaining;       // Words still to cross the bus
    xferLen_t  fetchLeft;       // Bank reads not yet issued
    logic      pendQ;           // Read issued last cycle
    logic      heldValidQ;
    dataWord   heldQ;
    logic      issue;
    logic      access;

    assign busy = (remaining != '0);
    assign outValid = heldValidQ || pendQ;
    assign outData = heldValidQ ? heldQ : cb.rdata[bankQ];

    // Fetch when the single word slot frees up
    assign issue = (fetchLeft != '0) && (!outValid || advance);
    assign access = writeQ ? advance : issue;

    always_comb begin
        cb.ce = '1;
        cb.ce[bankQ] = !access;
        cb.we = !(writeQ && advance);
        cb.addr = addrQ;
        cb.wdata = inData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writeQ <= 1'b0;
            bankQ <= 1'b0;
            remaining <= '0;
            fetchLeft <= '0;
            pendQ <= 1'b0;
            heldValidQ <= 1'b0;
        end
        else begin
            if (start) begin
                writeQ <= write;
                bankQ <= bank;
                remaining <= len;
                fetchLeft <= write ? '0 : len;  // Writes never prefetch
            end
            else begin
                if (advance) remaining <= remaining - 1'b1;
                if (issue) fetchLeft <= fetchLeft - 1'b1;
            end
            pendQ <= issue;
            if (advance) heldValidQ <= 1'b0;
            else if (pendQ) heldValidQ <= 1'b1;   // Park the unclaimed word
        end
    end

    always_ff @(posedge clk) begin
        if (start) addrQ <= sramAddr;
        else if (access) addrQ <= addrQ + 1'b1;
        if (pendQ && !advance) heldQ <= cb.rdata[bankQ];
    end

endmodule

/* hw/cacheBank.sv */
`timescale 1ns/1ps
`include "memc_params.svh"

module cacheBank import memcPkg::*; #(
    parameter int INDEX = 0
) (
    input logic   clk,
    cacheBus.bank cb
);

    localparam int DEPTH = 1 << `MEMC_SRAM_AW;

    dataWord mem [DEPTH];
    dataWord rdReg;

    assign cb.rdata[INDEX] = rdReg;

    always_ff @(posedge clk) begin
        if (!cb.ce[INDEX]) begin
            if (!cb.we) begin
                mem[cb.addr] <= cb.wdata;
            end
            else begin
                rdReg <= mem[cb.addr];  // Visible the cycle after
            end
        end
    end

endmodule

/* hw/cacheBus.sv */
`timescale 1ns/1ps
`include "memc_params.svh"

interface cacheBus import memcPkg::*; #(
    parameter int NUM_BANKS = `MEMC_NUM_BANKS
) ();

    logic [NUM_BANKS-1:0] ce;       // Active low, one per bank
    logic                 we;       // Active low, shared
    sramAddr_t            addr;
    dataWord              wdata;
    dataWord              rdata [NUM_BANKS];

    modport seq (
        output ce, we, addr, wdata,
        input  rdata
    );

    modport bank (
        input  ce, we, addr, wdata,
        output rdata
    );

endinterface

/* hw/memcPkg.sv */
`include "memc_params.svh"

package memcPkg;

    typedef logic [`MEMC_DATA_W-1:0] dataWord;
    typedef logic [`MEMC_SRAM_AW-1:0] sramAddr_t;
    typedef logic [`MEMC_EXT_AW-1:0] extAddr_t;     // Word address on the external bus
    typedef logic [`MEMC_LEN_W-1:0] xferLen_t;
    typedef logic [3:0] rqId_t;

    typedef enum logic [1:0] {
        MEMC_NONE            = 2'd0,
        MEMC_CP_CACHE_TO_EXT = 2'd1,
        MEMC_CP_EXT_TO_CACHE = 2'd2
    } memcCmd_t;

    typedef enum logic {
        CTRL_IDLE,
        CTRL_BUSY
    } ctrlState_t;

    typedef enum logic [1:0] {
        EXT_IDLE,
        EXT_HEADER,
        EXT_DATA
    } extState_t;

endpackage

/* hw/memc_params.svh */
`ifndef MEMC_PARAMS_SVH
`define MEMC_PARAMS_SVH

// Word and address widths
`define MEMC_DATA_W 32
`define MEMC_SRAM_AW 10
`define MEMC_EXT_AW 30

// Default number of cache banks
`define MEMC_NUM_BANKS 2

// Wide enough for a 128 word transfer
`define MEMC_LEN_W 8

`endif
